/* Makefile */
# Verilator build and run of the time-tagger testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_tagger
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
DATAFILE  ?= verif/tagger_testdata.hex
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(DATAFILE)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/bin_mem_arbiter.sv */
`timescale 1ns/1ns

module bin_mem_arbiter
    import tagger_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       sys_clk_rst,
    input  logic                       inc_valid_i,
    input  logic [bin_index_width-1:0] inc_bin_i,
    input  logic                       rd_req_i,
    input  logic [bin_index_width-1:0] rd_bin_i,
    input  logic                       clear_start_i,
    output logic                       inc_ready_o,
    output logic                       rd_done_o,
    output logic [bin_count_width-1:0] rd_count_o,
    output logic                       clear_busy_o
);

    logic [bin_count_width-1:0] mem [num_bins];
    logic                       inc_take;
    logic                       pipe_empty;
    logic                       rd_grant;
    logic                       rd_stage;
    logic                       s1_valid;
    logic [bin_index_width-1:0] s1_bin;
    logic [bin_count_width-1:0] s1_count;
    logic [bin_count_width-1:0] s1_fwd;
    logic                       s2_valid;
    logic [bin_index_width-1:0] s2_bin;
    logic [bin_count_width-1:0] s2_count;
    logic [bin_index_width-1:0] clear_idx;

    // Increments blocked only by the clear sweep
    assign inc_ready_o = !clear_busy_o;
    assign inc_take    = inc_valid_i && inc_ready_o;
    assign pipe_empty  = !s1_valid && !s2_valid;

    // Register reads fit into gaps of the increment stream
    assign rd_grant = rd_req_i && !rd_stage && !rd_done_o && !clear_busy_o
                    && !inc_valid_i && pipe_empty;

    // Write stage result for the same bin overrides the stale read
    assign s1_fwd = (s2_valid && s2_bin == s1_bin) ? s2_count : s1_count;

    // Pipeline and read handshake control
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rd_stage  <= 1'b0;
            rd_done_o <= 1'b0;
        end else begin
            s1_valid  <= inc_take;
            s2_valid  <= s1_valid;
            rd_stage  <= rd_grant;
            rd_done_o <= rd_stage;
        end
    end

    // Read stage, catches a write landing on the same edge
    always_ff @(posedge sys_clk) begin
        if (inc_take) begin
            s1_bin   <= inc_bin_i;
            s1_count <= (s2_valid && s2_bin == inc_bin_i) ? s2_count : mem[inc_bin_i];
        end
        if (s1_valid) begin
            s2_bin   <= s1_bin;
            s2_count <= s1_fwd + 1'b1;
        end
        if (rd_grant) begin
            rd_count_o <= mem[rd_bin_i];
        end
    end

    // Single write port, sweep waits for in-flight increments to land
    always_ff @(posedge sys_clk) begin
        if (clear_busy_o && pipe_empty) begin
            mem[clear_idx] <= '0;
        end else if (s2_valid) begin
            mem[s2_bin] <= s2_count;
        end
    end

    // Clear sweep, one bin per cycle, started by reset too
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst || clear_start_i) begin
            clear_busy_o <= 1'b1;
            clear_idx    <= '0;
        end else if (clear_busy_o && pipe_empty) begin
            clear_idx <= clear_idx + 1'b1;
            if (clear_idx == bin_index_width'(num_bins - 1)) begin
                clear_busy_o <= 1'b0;
            end
        end
    end

endmodule

/* hdl/start_stop_binner.sv */
`timescale 1ns/1ns

module start_stop_binner
    import tagger_pkg::*;
(
    input  logic                            sys_clk,
    input  logic                            sys_clk_rst,
    input  logic                            evt_valid_i,
    input  logic signed [channel_width-1:0] evt_channel_i,
    input  logic [time_width-1:0]           evt_time_i,
    input  logic signed [channel_width-1:0] start_channel_i,
    input  logic signed [channel_width-1:0] stop_channel_i,
    input  logic [shift_width-1:0]          shift_i,
    input  logic                            clear_busy_i,
    input  logic                            inc_ready_i,
    output logic                            evt_ready_o,
    output logic                            inc_valid_o,
    output logic [bin_index_width-1:0]      inc_bin_o,
    output logic                            binned_pulse_o
);

    logic [time_width-1:0] start_time;
    logic                  start_seen;
    logic                  evt_take;
    logic                  is_start;
    logic                  is_stop;
    logic [time_width-1:0] delay;
    logic                  bin_hit;

    // Stall only while a request waits on the arbiter
    assign evt_ready_o = !inc_valid_o || inc_ready_i;
    assign evt_take    = evt_valid_i && evt_ready_o;

    // Start wins when both channels are configured the same
    assign is_start = evt_channel_i == start_channel_i;
    assign is_stop  = !is_start && (evt_channel_i == stop_channel_i);

    // Stop before start in time wraps to a huge value and falls out of range
    assign delay   = (evt_time_i - start_time) >> shift_i;
    assign bin_hit = is_stop && start_seen && (delay < time_width'(num_bins));

    // Latest start time
    always_ff @(posedge sys_clk) begin
        if (evt_take && is_start) begin
            start_time <= evt_time_i;
        end
    end

    // Start-seen flag, dropped for the whole clear
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst || clear_busy_i) begin
            start_seen <= 1'b0;
        end else if (evt_take && is_start) begin
            start_seen <= 1'b1;
        end
    end

    // Increment request held until the arbiter takes it
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            inc_valid_o    <= 1'b0;
            binned_pulse_o <= 1'b0;
        end else begin
            binned_pulse_o <= evt_take && bin_hit;
            if (evt_take && bin_hit) begin
                inc_valid_o <= 1'b1;
            end else if (inc_ready_i) begin
                inc_valid_o <= 1'b0;
            end
        end
    end

    // Bin index of the pending request
    always_ff @(posedge sys_clk) begin
        if (evt_take && bin_hit) begin
            inc_bin_o <= delay[bin_index_width-1:0];
        end
    end

endmodule

/* hdl/tag_decoder.sv */
`timescale 1ns/1ns

module tag_decoder
    import tagger_pkg::*;
(
    input  logic                            sys_clk,
    input  logic                            sys_clk_rst,
    input  logic                            tag_valid_i,
    input  logic [tag_word_width-1:0]       tag_data_i,
    input  logic [wrap_width-1:0]           tag_wrap_i,
    input  logic                            evt_ready_i,
    output logic                            tag_ready_o,
    output logic                            evt_valid_o,
    output logic signed [channel_width-1:0] evt_channel_o,
    output logic [time_width-1:0]           evt_time_o
);

    logic [subtime_width-1:0] subtime;
    logic                     tag_take;

    // Fine time sits above the channel field
    assign subtime = tag_data_i[tag_word_width-1:channel_width];

    // Output register accepts when empty or emptying this cycle
    assign tag_ready_o = !evt_valid_o || evt_ready_i;
    assign tag_take    = tag_valid_i && tag_ready_o;

    // Valid flag of the one-entry output stage
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            evt_valid_o <= 1'b0;
        end else if (tag_take) begin
            evt_valid_o <= 1'b1;
        end else if (evt_ready_i) begin
            evt_valid_o <= 1'b0;
        end
    end

    // Decoded payload
    always_ff @(posedge sys_clk) begin
        if (tag_take) begin
            evt_channel_o <= tag_data_i[channel_width-1:0];
            // Wrap count forms the coarse part above the subtime
            evt_time_o    <= (time_width'(tag_wrap_i) << subtime_width)
                           | time_width'(subtime);
        end
    end

endmodule

/* hdl/tagger_pkg.sv */
package tagger_pkg;

    // Tag word layout, channel in the low bits and subtime above
    localparam int tag_word_width = 32;
    localparam int channel_width  = 6;
    localparam int subtime_width  = 26;
    localparam int wrap_width     = 32;
    localparam int time_width     = 64;

    // Histogram geometry
    localparam int num_bins        = 256;
    localparam int bin_index_width = 8;
    localparam int bin_count_width = 32;
    localparam int shift_width     = 5;

    // APB bus widths
    localparam int apb_addr_width = 12;
    localparam int apb_data_width = 32;

    // Register map
    localparam logic [apb_addr_width-1:0] reg_id          = 12'h000;
    localparam logic [apb_addr_width-1:0] reg_num_bins    = 12'h004;
    localparam logic [apb_addr_width-1:0] reg_config      = 12'h008;
    localparam logic [apb_addr_width-1:0] reg_control     = 12'h00C;
    localparam logic [apb_addr_width-1:0] reg_binned      = 12'h010;
    localparam logic [apb_addr_width-1:0] bin_window_base = 12'h400;

    // Field positions inside reg_config
    localparam int cfg_start_lsb = 0;
    localparam int cfg_stop_lsb  = 8;
    localparam int cfg_shift_lsb = 16;

    // Identity word returned by reg_id
    localparam int tagger_id_value = 1;

endpackage

/* hdl/tagger_regs.sv */
`timescale 1ns/1ns

module tagger_regs
    import tagger_pkg::*;
(
    input  logic                            sys_clk,
    input  logic                            sys_clk_rst,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [apb_addr_width-1:0]       paddr_i,
    input  logic [apb_data_width-1:0]       pwdata_i,
    input  logic                            binned_pulse_i,
    input  logic                            rd_done_i,
    input  logic [bin_count_width-1:0]     rd_count_i,
    input  logic                            clear_busy_i,
    output logic [apb_data_width-1:0]       prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic signed [channel_width-1:0] start_channel_o,
    output logic signed [channel_width-1:0] stop_channel_o,
    output logic [shift_width-1:0]          shift_o,
    output logic                            rd_req_o,
    output logic [bin_index_width-1:0]      rd_bin_o,
    output logic                            clear_start_o
);

    logic                      setup;
    logic                      in_window;
    logic                      win_read;
    logic                      mapped;
    logic [apb_data_width-1:0] rd_value;
    logic [apb_data_width-1:0] binned_count;

    // Decode in the setup phase so pready rises in the first access cycle
    assign setup     = psel_i && !penable_i;
    assign in_window = (paddr_i >= bin_window_base)
                     && (paddr_i < bin_window_base + 4 * num_bins);
    assign win_read  = in_window && !pwrite_i;

    // Register read mux, unmapped addresses read zero
    always_comb begin
        rd_value = '0;
        mapped   = 1'b1;
        case (paddr_i)
            reg_id:       rd_value = apb_data_width'(tagger_id_value);
            reg_num_bins: rd_value = apb_data_width'(num_bins);
            reg_config: begin
                rd_value[cfg_start_lsb +: channel_width] = start_channel_o;
                rd_value[cfg_stop_lsb +: channel_width]  = stop_channel_o;
                rd_value[cfg_shift_lsb +: shift_width]   = shift_o;
            end
            reg_control:  rd_value[0] = clear_busy_i;
            reg_binned:   rd_value = binned_count;
            default:      mapped = 1'b0;
        endcase
    end

    // APB completion, configuration and clear request
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            pready_o        <= 1'b0;
            pslverr_o       <= 1'b0;
            rd_req_o        <= 1'b0;
            clear_start_o   <= 1'b0;
            start_channel_o <= '0;
            stop_channel_o  <= '0;
            shift_o         <= '0;
        end else begin
            pready_o      <= 1'b0;
            clear_start_o <= 1'b0;
            if (setup && win_read) begin
                // Bin read waits for the arbiter
                rd_req_o <= 1'b1;
            end else if (setup) begin
                pready_o  <= 1'b1;
                pslverr_o <= !mapped;
                if (pwrite_i && paddr_i == reg_config) begin
                    start_channel_o <= pwdata_i[cfg_start_lsb +: channel_width];
                    stop_channel_o  <= pwdata_i[cfg_stop_lsb +: channel_width];
                    shift_o         <= pwdata_i[cfg_shift_lsb +: shift_width];
                end
                if (pwrite_i && paddr_i == reg_control) begin
                    clear_start_o <= pwdata_i[0];
                end
            end
            if (rd_done_i) begin
                rd_req_o  <= 1'b0;
                pready_o  <= 1'b1;
                pslverr_o <= 1'b0;
            end
        end
    end

    // Read data and bin index
    always_ff @(posedge sys_clk) begin
        if (setup) begin
            prdata_o <= pwrite_i ? '0 : rd_value;
            rd_bin_o <= paddr_i[2 +: bin_index_width];
        end else if (rd_done_i) begin
            prdata_o <= rd_count_i;
        end
    end

    // Stop tags that landed in a bin, zero while clearing
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst || clear_busy_i) begin
            binned_count <= '0;
        end else if (binned_pulse_i) begin
            binned_count <= binned_count + 1'b1;
        end
    end

endmodule

/* hdl/tagger_top.sv */
`timescale 1ns/1ns

module tagger_top
    import tagger_pkg::*;
(
    input  logic                      sys_clk,
    input  logic                      sys_clk_rst,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [apb_addr_width-1:0] paddr_i,
    input  logic [apb_data_width-1:0] pwdata_i,
    output logic [apb_data_width-1:0] prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  logic                      tag_valid_i,
    input  logic [tag_word_width-1:0] tag_data_i,
    input  logic [wrap_width-1:0]     tag_wrap_i,
    output logic                      tag_ready_o
);

    // Decoded event stream
    logic                            evt_valid;
    logic                            evt_ready;
    logic signed [channel_width-1:0] evt_channel;
    logic [time_width-1:0]           evt_time;

    // Increment requests into the bin memory
    logic                            inc_valid;
    logic                            inc_ready;
    logic [bin_index_width-1:0]      inc_bin;

    // Configuration and register side of the memory
    logic signed [channel_width-1:0] start_channel;
    logic signed [channel_width-1:0] stop_channel;
    logic [shift_width-1:0]          shift;
    logic                            binned_pulse;
    logic                            rd_req;
    logic [bin_index_width-1:0]      rd_bin;
    logic                            rd_done;
    logic [bin_count_width-1:0]      rd_count;
    logic                            clear_start;
    logic                            clear_busy;

    tag_decoder u_tag_decoder (
        .sys_clk       (sys_clk),
        .sys_clk_rst   (sys_clk_rst),
        .tag_valid_i   (tag_valid_i),
        .tag_data_i    (tag_data_i),
        .tag_wrap_i    (tag_wrap_i),
        .evt_ready_i   (evt_ready),
        .tag_ready_o   (tag_ready_o),
        .evt_valid_o   (evt_valid),
        .evt_channel_o (evt_channel),
        .evt_time_o    (evt_time)
    );

    start_stop_binner u_binner (
        .sys_clk         (sys_clk),
        .sys_clk_rst     (sys_clk_rst),
        .evt_valid_i     (evt_valid),
        .evt_channel_i   (evt_channel),
        .evt_time_i      (evt_time),
        .start_channel_i (start_channel),
        .stop_channel_i  (stop_channel),
        .shift_i         (shift),
        .clear_busy_i    (clear_busy),
        .inc_ready_i     (inc_ready),
        .evt_ready_o     (evt_ready),
        .inc_valid_o     (inc_valid),
        .inc_bin_o       (inc_bin),
        .binned_pulse_o  (binned_pulse)
    );

    bin_mem_arbiter u_arbiter (
        .sys_clk       (sys_clk),
        .sys_clk_rst   (sys_clk_rst),
        .inc_valid_i   (inc_valid),
        .inc_bin_i     (inc_bin),
        .rd_req_i      (rd_req),
        .rd_bin_i      (rd_bin),
        .clear_start_i (clear_start),
        .inc_ready_o   (inc_ready),
        .rd_done_o     (rd_done),
        .rd_count_o    (rd_count),
        .clear_busy_o  (clear_busy)
    );

    tagger_regs u_regs (
        .sys_clk         (sys_clk),
        .sys_clk_rst     (sys_clk_rst),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .binned_pulse_i  (binned_pulse),
        .rd_done_i       (rd_done),
        .rd_count_i      (rd_count),
        .clear_busy_i    (clear_busy),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .start_channel_o (start_channel),
        .stop_channel_o  (stop_channel),
        .shift_o         (shift),
        .rd_req_o        (rd_req),
        .rd_bin_o        (rd_bin),
        .clear_start_o   (clear_start)
    );

endmodule

/* src.f */
hdl/tagger_pkg.sv
hdl/tag_decoder.sv
hdl/start_stop_binner.sv
hdl/bin_mem_arbiter.sv
hdl/tagger_regs.sv
hdl/tagger_top.sv
verif/tb_tagger.sv

/* verif/tagger_testdata.hex */
// Words: config, tag count, then wrap count and tag word per tag,
// then expected binned count and expected counts of bins 0 to 255
00023E01
0000000C
00000002 00000C3E
00000000 0000FA01
00000000 0001043E
00000000 0001047E
00000000 00010682
00000000 0001067F
00000000 00020D3E
00000001 FFFFFC01
00000002 0000083E
00000002 0000087E
00000002 0000093E
00000002 0000FBFE
// Binned count, then bins 16 per row
00000006
0 0 0 0 0 0 0 0 0 0 2 0 2 1 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1

/* verif/tb_tagger.sv */
`timescale 1ns/1ns

module tb_tagger
    import tagger_pkg::*;
();

    // Data file holds config, tag count, wrap and tag pairs, binned count and one word per bin
    localparam int data_words     = 283;
    localparam int timeout_cycles = 2000;
    localparam int max_polls      = 400;

    logic                      sys_clk;
    logic                      sys_clk_rst;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      tag_valid;
    logic [tag_word_width-1:0] tag_data;
    logic [wrap_width-1:0]     tag_wrap;
    logic                      tag_ready;

    logic [31:0] tdata [data_words];
    integer      seed;
    int          n_tags;
    int          bins_at;
    logic [31:0] exp_binned;
    logic        tags_done;

    tagger_top dut (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .tag_valid_i (tag_valid),
        .tag_data_i  (tag_data),
        .tag_wrap_i  (tag_wrap),
        .tag_ready_o (tag_ready)
    );

    // 8 ns clock
    always #4 sys_clk = ~sys_clk;

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        if (got !== expv) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expv);
            stop_run();
        end
    endtask

    // Random idle cycles that keep the 1 ns offset after the edge
    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    // One APB access with a setup cycle and access cycles until pready
    task automatic apb_transfer(input logic write, input logic [apb_addr_width-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int cycles;
        idle_gap();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge sys_clk);
        #1;
        penable = 1'b1;
        cycles  = 0;
        // Registered pready holds its value here through the next edge
        while (!pready) begin
            @(posedge sys_clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("APB access to 0x%03h never completed", addr);
                stop_run();
            end
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge sys_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [apb_addr_width-1:0] addr, output logic [31:0] data);
        logic err;
        apb_transfer(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("pslverr_o read 0x%03h", addr), {31'd0, err}, 32'd0);
    endtask

    task automatic write_reg(input logic [apb_addr_width-1:0] addr, input logic [31:0] data);
        logic [31:0] rdata_ignored;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata_ignored, err);
        check_value($sformatf("pslverr_o write 0x%03h", addr), {31'd0, err}, 32'd0);
    endtask

    // Hold valid and data until the tag transfers
    task automatic send_tag(input logic [31:0] wrap, input logic [31:0] word);
        int   cycles;
        logic taken;
        idle_gap();
        tag_valid = 1'b1;
        tag_wrap  = wrap;
        tag_data  = word;
        taken     = 1'b0;
        cycles    = 0;
        while (!taken) begin
            // Ready comes from registers and stays stable up to the edge
            taken = tag_ready;
            @(posedge sys_clk);
            #1;
            cycles++;
            if (!taken && cycles > timeout_cycles) begin
                $display("Tag stream stalled, tag_ready_o never rose");
                stop_run();
            end
        end
        tag_valid = 1'b0;
    endtask

    task automatic send_all_tags();
        for (int k = 0; k < n_tags; k++) begin
            send_tag(tdata[2 + 2 * k], tdata[3 + 2 * k]);
        end
        tags_done = 1'b1;
    endtask

    // Low bins hold most of the hits in the data file
    task automatic poll_bins_midstream();
        logic [31:0] got;
        logic [31:0] limit;
        int          b;
        int          polls;
        polls = 0;
        while (!tags_done) begin
            polls++;
            if (polls > max_polls) begin
                $display("Tag stream never finished while bins were polled");
                stop_run();
            end
            b = $unsigned($random(seed)) % 16;
            read_reg(bin_window_base + apb_addr_width'(4 * b), got);
            limit = tdata[bins_at + b];
            // Any partial count up to the final one is legal
            check_value($sformatf("bin %0d mid-stream", b), (got > limit) ? got : limit, limit);
        end
    endtask

    task automatic wait_clear_done();
        logic [31:0] ctrl;
        int          polls;
        polls = 0;
        read_reg(reg_control, ctrl);
        while (ctrl[0]) begin
            polls++;
            if (polls > max_polls) begin
                $display("Clear sweep never finished, busy bit stays set");
                stop_run();
            end
            read_reg(reg_control, ctrl);
        end
    endtask

    // Binned counter reaches its final value once the last stop is accepted
    task automatic settle_binned(input logic [31:0] expv);
        logic [31:0] got;
        int          polls;
        polls = 0;
        read_reg(reg_binned, got);
        while (got != expv && polls < max_polls) begin
            polls++;
            read_reg(reg_binned, got);
        end
        check_value("reg_binned", got, expv);
    endtask

    task automatic check_histogram(input logic zero, input string phase);
        logic [31:0] got;
        logic [31:0] expv;
        for (int i = 0; i < num_bins; i++) begin
            read_reg(bin_window_base + apb_addr_width'(4 * i), got);
            expv = zero ? 32'd0 : tdata[bins_at + i];
            check_value($sformatf("bin %0d %s", i, phase), got, expv);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        seed        = 32'h9f6127d6;
        sys_clk     = 1'b0;
        sys_clk_rst = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        tag_valid   = 1'b0;
        tag_data    = '0;
        tag_wrap    = '0;
        tags_done   = 1'b0;
        $readmemh("verif/tagger_testdata.hex", tdata);
        n_tags  = tdata[1];
        bins_at = 3 + 2 * n_tags;
        if (bins_at + num_bins != data_words) begin
            $display("Test data file size does not match its tag count");
            stop_run();
        end
        exp_binned = tdata[2 + 2 * n_tags];

        repeat (3) @(posedge sys_clk);
        #1;
        sys_clk_rst = 1'b0;
        check_value("pready_o after reset", {31'd0, pready}, 32'd0);
        check_value("tag_ready_o after reset", {31'd0, tag_ready}, 32'd1);

        // Identity, size and the startup clear
        read_reg(reg_id, data);
        check_value("reg_id", data, 32'd1);
        read_reg(reg_num_bins, data);
        check_value("reg_num_bins", data, 32'd256);
        wait_clear_done();
        apb_transfer(1'b0, 12'h020, 32'd0, data, err);
        check_value("pslverr_o unmapped 0x020", {31'd0, err}, 32'd1);
        check_value("prdata_o unmapped 0x020", data, 32'd0);

        // Configuration round trip
        write_reg(reg_config, tdata[0]);
        read_reg(reg_config, data);
        check_value("reg_config", data, tdata[0]);

        // First pass with bin reads racing the stream
        fork
            send_all_tags();
            poll_bins_midstream();
        join
        settle_binned(exp_binned);
        check_histogram(1'b0, "first pass");

        // Clear through the control register
        write_reg(reg_control, 32'd1);
        read_reg(reg_control, data);
        check_value("reg_control busy", data, 32'd1);
        wait_clear_done();
        read_reg(reg_binned, data);
        check_value("reg_binned after clear", data, 32'd0);
        check_histogram(1'b1, "after clear");

        // Same tags again where a stale start would hit an extra bin
        tags_done = 1'b0;
        send_all_tags();
        settle_binned(exp_binned);
        check_histogram(1'b0, "second pass");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
